// ==== source/csr_arch_pkg.sv ====
// RV32 machine-mode CSR architecture; only mstatus.mie, mpie and mpp exist, other fields read zero
package csr_arch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    typedef logic [31:0] xlen_t;

    // Top two bits of 2'b11 mark a read-only CSR
    typedef logic [11:0] csr_addr_t;

    typedef logic [3:0] cause_code_t;

    ////////////////////////////////////////////////////////////////////////////
    // CSR addresses

    // Machine trap setup and handling
    localparam csr_addr_t MSTATUS   = 12'h300;
    localparam csr_addr_t MISA      = 12'h301;
    localparam csr_addr_t MIE       = 12'h304;
    localparam csr_addr_t MTVEC     = 12'h305;
    localparam csr_addr_t MSCRATCH  = 12'h340;
    localparam csr_addr_t MEPC      = 12'h341;
    localparam csr_addr_t MCAUSE    = 12'h342;
    localparam csr_addr_t MIP       = 12'h344;
    localparam csr_addr_t MHARTID   = 12'hF14;

    // Machine counters
    localparam csr_addr_t MCYCLE    = 12'hB00;
    localparam csr_addr_t MINSTRET  = 12'hB02;
    localparam csr_addr_t MCYCLEH   = 12'hB80;
    localparam csr_addr_t MINSTRETH = 12'hB82;

    // User read-only aliases
    localparam csr_addr_t CYCLE     = 12'hC00;
    localparam csr_addr_t INSTRET   = 12'hC02;
    localparam csr_addr_t CYCLEH    = 12'hC80;
    localparam csr_addr_t INSTRETH  = 12'hC82;

    ////////////////////////////////////////////////////////////////////////////
    // Interrupt codes, also the bit positions in mie and mip
    localparam cause_code_t M_SOFTWARE_IRQ = 4'd3;
    localparam cause_code_t M_TIMER_IRQ    = 4'd7;
    localparam cause_code_t M_EXTERNAL_IRQ = 4'd11;

    localparam logic [1:0] MACHINE_MODE = 2'b11;

    typedef struct packed {
        logic [18:0] zero_hi;
        logic [1:0]  mpp;
        logic [2:0]  zero_mid;
        logic        mpie;
        logic [2:0]  zero_lo;
        logic        mie;
        logic [2:0]  zero_low;
    } mstatus_t;

    localparam mstatus_t MSTATUS_RESET = '{mpp: MACHINE_MODE, default: '0};

    typedef struct packed {
        logic software;
        logic timer;
        logic external;
    } irq_t;

    // MXL = 1 (32 bit), base I only
    localparam xlen_t MISA_VALUE = 32'h4000_0100;

endpackage

// ==== source/csr_unit_pkg.sv ====
// Implementation types of the CSR unit; op encodings follow funct3 bits 1:0 of the CSR opcodes
package csr_unit_pkg;

    import csr_arch_pkg::*;

    typedef enum logic [1:0] {
        CSR_RW = 2'b01,
        CSR_RS = 2'b10,
        CSR_RC = 2'b11
    } csr_op_t;

    typedef logic [3:0] tag_t;

    // Issue request from the core
    typedef struct packed {
        csr_op_t   op;
        csr_addr_t addr;
        xlen_t     data;
        tag_t      tag;
    } csr_req_t;

    // Shared write bus, valid is a one-cycle strobe
    typedef struct packed {
        logic      valid;
        csr_addr_t addr;
        xlen_t     data;
    } csr_wr_t;

    // Flags are one-cycle strobes
    typedef struct packed {
        logic        exception;
        logic        interrupt_taken;
        logic        mret;
        cause_code_t code;
        xlen_t       pc;
    } trap_event_t;

    typedef enum logic [1:0] {
        IDLE,
        COMMIT,
        WAIT_ACK
    } access_state_t;

endpackage

// ==== source/csr_access.sv ====
// One CSR request in flight; rd_data returns the value before the write, writes land two edges after accept
`timescale 1ns/10ps

module csr_access
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
(
    input  logic      clk,
    input  logic      rst,

    // Issue
    input  logic      req_valid,
    input  csr_req_t  req,
    output logic      ready,

    // Writeback
    output logic      done,
    output xlen_t     rd_data,
    output tag_t      rd_tag,
    input  logic      ack,

    // CSR bus
    output csr_wr_t   wr,
    output csr_addr_t rd_addr,
    input  xlen_t     trap_rdata,
    input  xlen_t     counter_rdata
);

    access_state_t state;
    csr_req_t      req_r;
    xlen_t         old_value;
    xlen_t         new_value;
    logic          accept;
    logic          commit;
    logic          writable;

    assign ready  = (state == IDLE);
    assign done   = (state == WAIT_ACK);
    assign accept = req_valid & ready;
    assign commit = (state == COMMIT);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (accept) state <= COMMIT;
                COMMIT:   state <= WAIT_ACK;
                WAIT_ACK: if (ack) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_r <= req;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read-modify-write

    // Banks return zero for foreign addresses
    assign rd_addr   = req_r.addr;
    assign old_value = trap_rdata | counter_rdata;
    assign writable  = (req_r.addr[11:10] != 2'b11);

    always_comb begin
        case (req_r.op)
            CSR_RS:  new_value = old_value | req_r.data;
            CSR_RC:  new_value = old_value & ~req_r.data;
            default: new_value = req_r.data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr.valid <= 1'b0;
        end else begin
            wr.valid <= commit & writable;
        end
        if (commit) begin
            wr.addr <= req_r.addr;
            wr.data <= new_value;
        end
    end

    // Writeback payload, held while done waits for ack
    always_ff @(posedge clk) begin
        if (commit) begin
            rd_data <= old_value;
            rd_tag  <= req_r.tag;
        end
    end

endmodule

// ==== source/csr_trap_regs.sv ====
// Machine trap CSRs; trap strobes override a same-cycle bus write, mcause writes keep bit 31 and code only
`timescale 1ns/10ps

module csr_trap_regs
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
#(
    parameter xlen_t RESET_MTVEC = 32'h0000_0100,
    parameter xlen_t HART_ID     = 32'h0
)
(
    input  logic        clk,
    input  logic        rst,
    input  csr_wr_t     wr,
    input  csr_addr_t   rd_addr,
    input  trap_event_t trap,
    input  irq_t        irq,
    output xlen_t       trap_rdata,
    output xlen_t       exception_target_pc,
    output xlen_t       epc,
    output logic        interrupt_pending
);

    mstatus_t    mstatus;
    mstatus_t    wr_status;
    xlen_t       mtvec;
    xlen_t       mepc;
    xlen_t       mscratch;
    logic        mcause_irq;
    cause_code_t mcause_code;
    irq_t        mie;
    irq_t        mip;
    irq_t        irq_active;
    cause_code_t irq_code;
    logic        trap_entry;

    function automatic logic wr_hit(input csr_addr_t addr);
        return wr.valid && (wr.addr == addr);
    endfunction

    // mie/mip layout: one bit per line at its cause code
    function automatic xlen_t irq_to_word(input irq_t lines);
        xlen_t word;
        word = '0;
        word[M_SOFTWARE_IRQ] = lines.software;
        word[M_TIMER_IRQ]    = lines.timer;
        word[M_EXTERNAL_IRQ] = lines.external;
        return word;
    endfunction

    function automatic irq_t word_to_irq(input xlen_t word);
        irq_t lines;
        lines.software = word[M_SOFTWARE_IRQ];
        lines.timer    = word[M_TIMER_IRQ];
        lines.external = word[M_EXTERNAL_IRQ];
        return lines;
    endfunction

    assign trap_entry = trap.exception | trap.interrupt_taken;
    assign wr_status  = mstatus_t'(wr.data);

    ////////////////////////////////////////////////////////////////////////////
    // Interrupts
    always_ff @(posedge clk) begin
        if (rst) begin
            mip <= '0;
        end else begin
            mip <= irq;
        end
    end

    assign irq_active        = mip & mie;
    assign interrupt_pending = (|irq_active) & mstatus.mie;

    // External beats timer beats software
    always_comb begin
        if (irq_active.external) begin
            irq_code = M_EXTERNAL_IRQ;
        end else if (irq_active.timer) begin
            irq_code = M_TIMER_IRQ;
        end else begin
            irq_code = M_SOFTWARE_IRQ;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Trap registers
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= MSTATUS_RESET;
        end else if (trap_entry) begin
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= MACHINE_MODE;
        end else if (trap.mret) begin
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
        end else if (wr_hit(MSTATUS)) begin
            // Machine mode only, so mpp keeps its single legal value
            mstatus.mie  <= wr_status.mie;
            mstatus.mpie <= wr_status.mpie;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= {RESET_MTVEC[31:2], 2'b00};
        end else if (wr_hit(MTVEC)) begin
            mtvec <= {wr.data[31:2], 2'b00};
        end
        if (rst) begin
            mie <= '0;
        end else if (wr_hit(MIE)) begin
            mie <= word_to_irq(wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (trap_entry) begin
            mepc <= {trap.pc[31:2], 2'b00};
        end else if (wr_hit(MEPC)) begin
            mepc <= {wr.data[31:2], 2'b00};
        end
        if (wr_hit(MSCRATCH)) begin
            mscratch <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_irq  <= 1'b0;
            mcause_code <= '0;
        end else if (trap.interrupt_taken) begin
            mcause_irq  <= 1'b1;
            mcause_code <= irq_code;
        end else if (trap.exception) begin
            mcause_irq  <= 1'b0;
            mcause_code <= trap.code;
        end else if (wr_hit(MCAUSE)) begin
            mcause_irq  <= wr.data[31];
            mcause_code <= wr.data[3:0];
        end
    end

    assign exception_target_pc = mtvec;
    assign epc                 = mepc;

    ////////////////////////////////////////////////////////////////////////////
    // Read decode
    always_comb begin
        case (rd_addr)
            MSTATUS:  trap_rdata = mstatus;
            MISA:     trap_rdata = MISA_VALUE;
            MIE:      trap_rdata = irq_to_word(mie);
            MTVEC:    trap_rdata = mtvec;
            MSCRATCH: trap_rdata = mscratch;
            MEPC:     trap_rdata = mepc;
            MCAUSE:   trap_rdata = {mcause_irq, 27'b0, mcause_code};
            MIP:      trap_rdata = irq_to_word(mip);
            MHARTID:  trap_rdata = HART_ID;
            default:  trap_rdata = '0;
        endcase
    end

endmodule

// ==== source/csr_counters.sv ====
// Cycle and retire counters of COUNTER_W bits (33 to 64); retire_count above RETIRE_PORTS is clamped
`timescale 1ns/10ps

module csr_counters
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
#(
    parameter int COUNTER_W    = 64,
    parameter int RETIRE_PORTS = 3
)
(
    input  logic       clk,
    input  logic       rst,
    input  csr_wr_t    wr,
    input  csr_addr_t  rd_addr,
    input  logic [1:0] retire_count,
    output xlen_t      counter_rdata
);

    localparam int HI_W = COUNTER_W - 32;

    logic [COUNTER_W-1:0] mcycle;
    logic [COUNTER_W-1:0] minstret;
    logic [1:0]           retire_inc;

    // A write to either half loads the value and skips the increment
    function automatic logic [COUNTER_W-1:0] next_count(
        input logic [COUNTER_W-1:0] cur,
        input csr_addr_t            lo_addr,
        input csr_addr_t            hi_addr,
        input logic [COUNTER_W-1:0] inc
    );
        logic [COUNTER_W-1:0] nxt;
        nxt = cur + inc;
        if (wr.valid && wr.addr == lo_addr) begin
            nxt = {cur[COUNTER_W-1:32], wr.data};
        end
        if (wr.valid && wr.addr == hi_addr) begin
            nxt = {wr.data[HI_W-1:0], cur[31:0]};
        end
        return nxt;
    endfunction

    assign retire_inc = (int'(retire_count) > RETIRE_PORTS) ? 2'(RETIRE_PORTS) : retire_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle   <= next_count(mcycle, MCYCLE, MCYCLEH, COUNTER_W'(1));
            minstret <= next_count(minstret, MINSTRET, MINSTRETH, COUNTER_W'(retire_inc));
        end
    end

    // User aliases share the machine values
    always_comb begin
        case (rd_addr)
            MCYCLE, CYCLE:       counter_rdata = mcycle[31:0];
            MCYCLEH, CYCLEH:     counter_rdata = xlen_t'(mcycle[COUNTER_W-1:32]);
            MINSTRET, INSTRET:   counter_rdata = minstret[31:0];
            MINSTRETH, INSTRETH: counter_rdata = xlen_t'(minstret[COUNTER_W-1:32]);
            default:             counter_rdata = '0;
        endcase
    end

endmodule

// ==== source/csr_unit.sv ====
// Machine-mode CSR unit top; sequencer masters one write and read bus shared by two register banks
`timescale 1ns/10ps

module csr_unit
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
#(
    parameter xlen_t RESET_MTVEC  = 32'h0000_0100,
    parameter xlen_t HART_ID      = 32'h0,
    parameter int    COUNTER_W    = 64,
    parameter int    RETIRE_PORTS = 3
)
(
    input  logic        clk,
    input  logic        rst,

    // Issue and writeback
    input  logic        req_valid,
    input  csr_req_t    req,
    output logic        ready,
    output logic        done,
    output xlen_t       rd_data,
    output tag_t        rd_tag,
    input  logic        ack,

    // Traps and interrupts
    input  trap_event_t trap,
    input  irq_t        irq,
    output xlen_t       exception_target_pc,
    output xlen_t       epc,
    output logic        interrupt_pending,

    input  logic [1:0]  retire_count
);

    csr_wr_t   wr;
    csr_addr_t rd_addr;
    xlen_t     trap_rdata;
    xlen_t     counter_rdata;

    csr_access access_i (
        .clk, .rst, .req_valid, .req, .ack, .trap_rdata, .counter_rdata,
        .ready, .done, .rd_data, .rd_tag, .wr, .rd_addr
    );

    csr_trap_regs #(
        .RESET_MTVEC (RESET_MTVEC),
        .HART_ID     (HART_ID)
    ) trap_regs_i (
        .clk, .rst, .wr, .rd_addr, .trap, .irq,
        .trap_rdata, .exception_target_pc, .epc, .interrupt_pending
    );

    csr_counters #(
        .COUNTER_W    (COUNTER_W),
        .RETIRE_PORTS (RETIRE_PORTS)
    ) counters_i (
        .clk, .rst, .wr, .rd_addr, .retire_count, .counter_rdata
    );

endmodule

// ==== test/csr_properties.sv ====
// Handshake assertions for csr_access, checked on the rising clk edge and idle while rst is high
`timescale 1ns/10ps

module csr_properties (
    input logic clk,
    input logic rst,
    input logic req_valid,
    input logic ready,
    input logic done,
    input logic ack,
    input logic wr_valid
);

    // One commit cycle between acceptance and done, with issue closed meanwhile
    accept_to_done: assert property (@(posedge clk) disable iff (rst)
        req_valid && ready |=> !ready && !done ##1 done)
        else $error("done did not rise one cycle after the request was accepted");

    // Write strobe marks the commit cycle only
    write_on_commit: assert property (@(posedge clk) disable iff (rst)
        wr_valid |-> done && !$past(done))
        else $error("write strobe outside the cycle in which done rises");

    done_until_ack: assert property (@(posedge clk) disable iff (rst) done && !ack |=> done)
        else $error("done dropped before ack");

endmodule

bind csr_access csr_properties handshake_props (
    .clk,
    .rst,
    .req_valid,
    .ready,
    .done,
    .ack,
    .wr_valid (wr.valid)
);

// ==== test/csr_checker.sv ====
// Compares csr_unit responses with expected values; read checks use the last response acked
`timescale 1ns/10ps

module csr_checker
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  ready,
    input logic  done,
    input logic  ack,
    input xlen_t rd_data,
    input tag_t  rd_tag,
    input xlen_t exception_target_pc,
    input xlen_t epc,
    input logic  interrupt_pending
);

    int    errors = 0;
    int    passes = 0;
    xlen_t resp_data;
    tag_t  resp_tag;

    // Response as it leaves the writeback port
    always @(posedge clk) begin
        if (!rst && done && ack) begin
            resp_data <= rd_data;
            resp_tag  <= rd_tag;
        end
    end

    task automatic report(input string name, input logic [63:0] expected,
                          input logic [63:0] actual);
        if (actual === expected) begin
            passes++;
            $display("ok %s", name);
        end else begin
            errors++;
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic check_read(input string name, input xlen_t expected, input tag_t tag);
        if (resp_tag !== tag) begin
            errors++;
            $display("mismatch %s expected tag %0h actual tag %0h", name, tag, resp_tag);
        end else begin
            report(name, 64'(expected), 64'(resp_data));
        end
    endtask

    // Both bounds exclusive
    task automatic check_range(input string name, input xlen_t low, input xlen_t high,
                               input tag_t tag);
        if (resp_tag === tag && resp_data > low && resp_data < high) begin
            passes++;
            $display("ok %s", name);
        end else begin
            errors++;
            $display("mismatch %s expected %0d..%0d actual %0d", name, low, high, resp_data);
        end
    endtask

    task automatic check_trap_outputs(input string name, input xlen_t target, input xlen_t pc);
        if (exception_target_pc !== target) begin
            errors++;
            $display("mismatch %s expected target %0h actual %0h", name, target,
                     exception_target_pc);
        end else begin
            report(name, 64'(pc), 64'(epc));
        end
    endtask

    task automatic check_pending(input string name, input logic level);
        report(name, 64'(level), 64'(interrupt_pending));
    endtask

    task automatic check_idle(input string name);
        report(name, 64'(2'b10), 64'({ready, done}));
    endtask

endmodule

// ==== test/csr_unit_tb.sv ====
// Table-driven csr_unit test with HART_ID 5 and RESET_MTVEC 0x100, default counter parameters
`timescale 1ns/10ps

module csr_unit_tb
    import csr_arch_pkg::*;
    import csr_unit_pkg::*;
();

    localparam int    TIMEOUT    = 50;
    localparam xlen_t SCRATCH_A  = 32'hA5A5_0F0F;
    localparam xlen_t SCRATCH_B  = 32'h0000_F0F0;
    localparam xlen_t SCRATCH_C  = 32'h00FF_00FF;
    localparam irq_t  TIMER_LINE = '{software: 1'b0, timer: 1'b1, external: 1'b0};

    typedef enum logic [3:0] {
        DO_IDLE, DO_CSR, DO_WRITE, DO_RANGE, DO_RETIRED, DO_EXCEPTION, DO_INTERRUPT,
        DO_MRET, DO_IRQ_LINES, DO_PENDING, DO_TRAP_OUTPUTS, DO_RETIRE
    } action_t;

    // Trap rows: data is the pc, exp the cause code or target pc, data the epc for outputs
    typedef struct packed {
        action_t   act;
        csr_op_t   op;
        csr_addr_t addr;
        xlen_t     data;
        xlen_t     exp;
        xlen_t     exp_hi;
    } step_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    csr_req_t    req;
    logic        ready;
    logic        done;
    xlen_t       rd_data;
    tag_t        rd_tag;
    logic        ack;
    trap_event_t trap;
    irq_t        irq;
    xlen_t       exception_target_pc;
    xlen_t       epc;
    logic        interrupt_pending;
    logic [1:0]  retire_count;

    string names[$];
    step_t steps[$];
    int    driver_failures = 0;
    int    retire_sum = 0;
    int    seed = 32'hdd56c554;

    always #10 clk = ~clk;

    csr_unit #(
        .RESET_MTVEC (32'h0000_0100),
        .HART_ID     (32'd5)
    ) DUT (
        .clk, .rst, .req_valid, .req, .ready, .done, .rd_data, .rd_tag, .ack,
        .trap, .irq, .exception_target_pc, .epc, .interrupt_pending, .retire_count
    );

    csr_checker checks (
        .clk, .rst, .ready, .done, .ack, .rd_data, .rd_tag,
        .exception_target_pc, .epc, .interrupt_pending
    );

    task automatic add_step(input string name, input action_t act, input csr_op_t op,
                            input csr_addr_t addr, input xlen_t data, input xlen_t exp);
        step_t s;
        s.act    = act;
        s.op     = op;
        s.addr   = addr;
        s.data   = data;
        s.exp    = exp;
        s.exp_hi = '0;
        names.push_back(name);
        steps.push_back(s);
    endtask

    task automatic add_range(input string name, input csr_addr_t addr, input xlen_t low,
                             input xlen_t high);
        add_step(name, DO_RANGE, CSR_RS, addr, '0, low);
        steps[steps.size() - 1].exp_hi = high;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drivers

    task automatic run_request(input string name, input step_t s, input tag_t tag,
                               output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!ready && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!ready) begin
            driver_failures++;
            $display("%s: ready stayed low for %0d cycles", name, TIMEOUT);
            return;
        end
        req_valid = 1'b1;
        req.op    = s.op;
        req.addr  = s.addr;
        req.data  = s.data;
        req.tag   = tag;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        cycles = 0;
        while (!done && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            driver_failures++;
            $display("%s: done did not rise within %0d cycles", name, TIMEOUT);
            return;
        end
        ack = 1'b1;
        @(posedge clk);
        #1;
        ack = 1'b0;
        ok = 1'b1;
    endtask

    task automatic pulse_trap(input trap_event_t ev);
        trap = ev;
        @(posedge clk);
        #1;
        trap = '0;
    endtask

    task automatic run_step(input string name, input step_t s, input tag_t tag);
        logic        ok;
        int          cycles;
        logic [1:0]  retire_value;
        trap_event_t ev;
        ev = '0;
        case (s.act)
            DO_IDLE: begin
                checks.check_idle(name);
            end
            DO_CSR, DO_WRITE, DO_RANGE, DO_RETIRED: begin
                run_request(name, s, tag, ok);
                if (ok && s.act == DO_CSR) begin
                    checks.check_read(name, s.exp, tag);
                end else if (ok && s.act == DO_RANGE) begin
                    checks.check_range(name, s.exp, s.exp_hi, tag);
                end else if (ok && s.act == DO_RETIRED) begin
                    checks.check_read(name, s.exp + xlen_t'(retire_sum), tag);
                end
            end
            DO_EXCEPTION: begin
                ev.exception = 1'b1;
                ev.code      = s.exp[3:0];
                ev.pc        = s.data;
                pulse_trap(ev);
            end
            DO_INTERRUPT: begin
                ev.interrupt_taken = 1'b1;
                ev.pc              = s.data;
                pulse_trap(ev);
            end
            DO_MRET: begin
                ev.mret = 1'b1;
                pulse_trap(ev);
            end
            DO_IRQ_LINES: begin
                irq = irq_t'(s.data[2:0]);
            end
            DO_PENDING: begin
                cycles = 0;
                while (interrupt_pending !== s.exp[0] && cycles < TIMEOUT) begin
                    @(posedge clk);
                    #1;
                    cycles++;
                end
                if (interrupt_pending !== s.exp[0]) begin
                    $display("%s: interrupt_pending did not reach %0b within %0d cycles",
                             name, s.exp[0], TIMEOUT);
                end
                checks.check_pending(name, s.exp[0]);
            end
            DO_TRAP_OUTPUTS: begin
                checks.check_trap_outputs(name, s.exp, s.data);
            end
            DO_RETIRE: begin
                // Each value is counted on the following edge
                repeat (s.data) begin
                    retire_value = 2'($random(seed));
                    retire_count = retire_value;
                    retire_sum += int'(retire_value);
                    @(posedge clk);
                    #1;
                end
                retire_count = '0;
            end
            default: begin
                driver_failures++;
                $display("%s: step has an unknown action", name);
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus table

    initial begin
        add_step("idle_after_reset", DO_IDLE, CSR_RW, '0, '0, '0);
        add_step("mstatus_reset", DO_CSR, CSR_RS, MSTATUS, '0, 32'h0000_1800);
        add_step("mtvec_reset", DO_CSR, CSR_RS, MTVEC, '0, 32'h0000_0100);
        add_step("mhartid", DO_CSR, CSR_RS, MHARTID, '0, 32'd5);
        add_step("misa", DO_CSR, CSR_RS, MISA, '0, MISA_VALUE);
        add_step("mscratch_seed", DO_WRITE, CSR_RW, MSCRATCH, 32'h1234_5678, '0);
        add_step("mscratch_rw", DO_CSR, CSR_RW, MSCRATCH, SCRATCH_A, 32'h1234_5678);
        add_step("mscratch_rs", DO_CSR, CSR_RS, MSCRATCH, SCRATCH_B, SCRATCH_A);
        add_step("mscratch_rc", DO_CSR, CSR_RC, MSCRATCH, SCRATCH_C, SCRATCH_A | SCRATCH_B);
        add_step("mscratch_final", DO_CSR, CSR_RS, MSCRATCH, '0,
                 (SCRATCH_A | SCRATCH_B) & ~SCRATCH_C);
        add_step("mtvec_ones", DO_CSR, CSR_RW, MTVEC, '1, 32'h0000_0100);
        add_step("mtvec_masked", DO_CSR, CSR_RS, MTVEC, '0, 32'hFFFF_FFFC);
        add_step("mie_ones", DO_CSR, CSR_RW, MIE, '1, '0);
        add_step("mie_masked", DO_CSR, CSR_RC, MIE, '1, 32'h0000_0888);
        add_step("misa_write", DO_CSR, CSR_RW, MISA, '0, MISA_VALUE);
        add_step("misa_kept", DO_CSR, CSR_RS, MISA, '0, MISA_VALUE);
        add_step("unknown_write", DO_CSR, CSR_RW, 12'h7C0, '1, '0);
        add_step("unknown_read", DO_CSR, CSR_RS, 12'h7C0, '0, '0);
        add_step("mtvec_set", DO_CSR, CSR_RW, MTVEC, 32'h0000_0200, 32'hFFFF_FFFC);
        // Exception and return
        add_step("mstatus_mie_set", DO_CSR, CSR_RS, MSTATUS, 32'h8, 32'h0000_1800);
        add_step("exception", DO_EXCEPTION, CSR_RW, '0, 32'h0000_2006, 32'd2);
        add_step("trap_outputs", DO_TRAP_OUTPUTS, CSR_RW, '0, 32'h0000_2004, 32'h0000_0200);
        add_step("mepc", DO_CSR, CSR_RS, MEPC, '0, 32'h0000_2004);
        add_step("mcause_exception", DO_CSR, CSR_RS, MCAUSE, '0, 32'd2);
        add_step("mstatus_trapped", DO_CSR, CSR_RS, MSTATUS, '0, 32'h0000_1880);
        add_step("mret", DO_MRET, CSR_RW, '0, '0, '0);
        add_step("mstatus_returned", DO_CSR, CSR_RS, MSTATUS, '0, 32'h0000_1888);
        // Timer interrupt
        add_step("mie_mtie", DO_CSR, CSR_RW, MIE, 32'h0000_0080, '0);
        add_step("irq_timer", DO_IRQ_LINES, CSR_RW, '0, {29'b0, TIMER_LINE}, '0);
        add_step("pending_high", DO_PENDING, CSR_RW, '0, '0, 32'd1);
        add_step("interrupt_taken", DO_INTERRUPT, CSR_RW, '0, 32'h0000_3000, '0);
        add_step("pending_low", DO_PENDING, CSR_RW, '0, '0, 32'd0);
        add_step("mcause_interrupt", DO_CSR, CSR_RS, MCAUSE, '0, 32'h8000_0007);
        add_step("irq_clear", DO_IRQ_LINES, CSR_RW, '0, '0, '0);
        // Counters
        add_step("minstret_write", DO_CSR, CSR_RW, MINSTRET, 32'd100, '0);
        add_step("retire", DO_RETIRE, CSR_RW, '0, 32'd20, '0);
        add_step("instret_sum", DO_RETIRED, CSR_RS, INSTRET, '0, 32'd100);
        add_step("mcycle_write", DO_WRITE, CSR_RW, MCYCLE, 32'd1000, '0);
        add_range("mcycle_later", CYCLE, 32'd1000, 32'd1100);
        add_step("cycleh", DO_CSR, CSR_RS, CYCLEH, '0, '0);

        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        ack          = 1'b0;
        trap         = '0;
        irq          = '0;
        retire_count = '0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        foreach (steps[i]) begin
            run_step(names[i], steps[i], tag_t'(i));
        end

        $display("tests %0d passed %0d failed %0d",
                 checks.passes + checks.errors + driver_failures, checks.passes,
                 checks.errors + driver_failures);
        if (checks.errors == 0 && driver_failures == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
source/csr_arch_pkg.sv
source/csr_unit_pkg.sv
source/csr_access.sv
source/csr_trap_regs.sv
source/csr_counters.sv
source/csr_unit.sv
test/csr_properties.sv
test/csr_checker.sv
test/csr_unit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the csr_unit testbench with Verilator, runs it and scans the log for failures
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module csr_unit_tb \
    -f verilog.f \
    -o csr_unit_sim

./obj_dir/csr_unit_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
